// ==== dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int ADDR_W  = 10;
    localparam int INDEX_W = 4;
    localparam int DATA_W  = 32;
    localparam int TAG_W   = ADDR_W - INDEX_W;

    // MIPS primary opcodes
    localparam logic [5:0] OP_LW = 6'b100011;
    localparam logic [5:0] OP_SW = 6'b101011;

    // ====================
    // Types
    // ====================
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              start;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              ready;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        COMPARE,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== line_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_array #(
    parameter type entry_t = logic,
    parameter int  INDEX_W = 4
) (
    input  wire                clk,
    input  wire                rst_b,
    input  wire  [INDEX_W-1:0] index,
    input  wire                we,
    input  wire  entry_t       wentry,
    output entry_t             rentry
);

    localparam int DEPTH = 2 ** INDEX_W;

    entry_t lines [DEPTH];

    // Clearing every entry drops all valid bits in the tag array
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < DEPTH; i++) begin
                lines[i] <= '0;
            end
        end else if (we) begin
            lines[index] <= wentry;
        end
    end

    // Asynchronous read
    assign rentry = lines[index];

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire        clk,
    input  wire        rst_b,
    input  wire  [5:0] opcode,
    input  wire        hit,
    input  wire        dirty,
    input  wire        mem_ready,
    output logic       cache_we,
    output logic       cache_in_select,
    output logic       mem_in_select,
    output logic       mem_start,
    output logic       mem_we,
    output logic       done,
    output logic       stall
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_next;

    logic is_lw;
    logic is_sw;
    logic mem_op;

    assign is_lw  = (opcode == dcache_pkg::OP_LW);
    assign is_sw  = (opcode == dcache_pkg::OP_SW);
    assign mem_op = is_lw || is_sw;

    // ====================
    // Next state and outputs
    // ====================
    always_comb begin
        state_next      = state;
        cache_we        = 1'b0;
        cache_in_select = 1'b0;
        mem_in_select   = 1'b0;
        mem_we          = 1'b0;
        done            = 1'b0;
        stall           = 1'b0;

        case (state)
            dcache_pkg::COMPARE: begin
                if (mem_op) begin
                    if (hit) begin
                        done = 1'b1;
                        // Store hit writes the word and marks the line dirty
                        if (is_sw) begin
                            cache_we        = 1'b1;
                            cache_in_select = 1'b1;
                        end
                    end else begin
                        stall = 1'b1;
                        if (dirty) begin
                            state_next = dcache_pkg::WRITEBACK;
                        end else begin
                            state_next = dcache_pkg::REFILL;
                        end
                    end
                end
            end

            dcache_pkg::WRITEBACK: begin
                // Victim address and write enable held for the whole access
                stall         = 1'b1;
                mem_in_select = 1'b1;
                mem_we        = 1'b1;
                if (mem_ready) begin
                    state_next = dcache_pkg::REFILL;
                end
            end

            dcache_pkg::REFILL: begin
                stall = 1'b1;
                if (mem_ready) begin
                    // Read data is valid now, fill the line clean
                    cache_we   = 1'b1;
                    state_next = dcache_pkg::COMPARE;
                end
            end

            default: begin
                state_next = dcache_pkg::COMPARE;
            end
        endcase
    end

    // ====================
    // State register
    // ====================
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state     <= dcache_pkg::COMPARE;
            mem_start <= 1'b0;
        end else begin
            state <= state_next;
            // One start pulse in the first cycle of each memory phase
            mem_start <= (state_next != state) && (state_next != dcache_pkg::COMPARE);
        end
    end

endmodule

`default_nettype wire

// ==== cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_datapath #(
    parameter int ADDR_W  = 10,
    parameter int INDEX_W = 4,
    parameter int DATA_W  = 32
) (
    input  wire  dcache_pkg::cpu_req_t   req,
    input  wire  dcache_pkg::tag_entry_t rtag,
    input  wire  [DATA_W-1:0]            rdata_line,
    input  wire                          cache_in_select,
    input  wire                          mem_in_select,
    input  wire                          mem_start,
    input  wire                          mem_we,
    input  wire  dcache_pkg::mem_rsp_t   mem_rsp,
    output logic                         hit,
    output logic                         dirty,
    output logic [INDEX_W-1:0]           index,
    output dcache_pkg::tag_entry_t       wtag,
    output logic [DATA_W-1:0]            wdata_line,
    output dcache_pkg::mem_req_t         mem_req,
    output logic [DATA_W-1:0]            rdata
);

    localparam int TAG_W = ADDR_W - INDEX_W;

    logic [TAG_W-1:0]  req_tag;
    logic [ADDR_W-1:0] victim_addr;

    assign index   = req.addr[INDEX_W-1:0];
    assign req_tag = req.addr[ADDR_W-1:INDEX_W];

    // ====================
    // Lookup
    // ====================
    assign hit   = rtag.valid && (rtag.tag == req_tag);
    // Only meaningful on a miss, where the line is the victim
    assign dirty = rtag.valid && rtag.dirty;

    // ====================
    // Array write data
    // ====================
    always_comb begin
        wtag.valid = 1'b1;
        wtag.dirty = cache_in_select;
        wtag.tag   = req_tag;
    end

    assign wdata_line = cache_in_select ? req.wdata : mem_rsp.rdata;

    // ====================
    // Memory request
    // ====================
    assign victim_addr = {rtag.tag, index};

    always_comb begin
        mem_req.start = mem_start;
        mem_req.we    = mem_we;
        mem_req.addr  = mem_in_select ? victim_addr : req.addr;
        // Victim word goes out on write-back
        mem_req.wdata = rdata_line;
    end

    // Load data straight from the line
    assign rdata = rdata_line;

endmodule

`default_nettype wire

// ==== main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_mem #(
    parameter int MEM_LAT = 4,
    parameter int ADDR_W  = 10,
    parameter int DATA_W  = 32
) (
    input  wire                        clk,
    input  wire                        rst_b,
    input  wire  dcache_pkg::mem_req_t req,
    output dcache_pkg::mem_rsp_t       rsp
);

    localparam int DEPTH = 2 ** ADDR_W;
    localparam int CNT_W = $clog2(MEM_LAT) + 1;

    logic [DATA_W-1:0] words [DEPTH];

    logic              busy;
    logic [CNT_W-1:0]  cnt;
    logic              we_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              ready;

    // Ready lands MEM_LAT cycles after the start pulse
    assign ready = busy && (cnt == '0);

    // ====================
    // Request tracking
    // ====================
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (req.start) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(MEM_LAT - 1);
        end else if (ready) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            we_q    <= req.we;
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
    end

    // ====================
    // Storage
    // ====================
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= '0;
            end
        end else if (ready && we_q) begin
            words[addr_q] <= wdata_q;
        end
    end

    always_comb begin
        rsp.ready = ready;
        rsp.rdata = words[addr_q];
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int ADDR_W  = dcache_pkg::ADDR_W,
    parameter int INDEX_W = dcache_pkg::INDEX_W,
    parameter int DATA_W  = dcache_pkg::DATA_W,
    parameter int MEM_LAT = 4
) (
    input  wire                        clk,
    input  wire                        rst_b,
    input  wire  dcache_pkg::cpu_req_t req,
    output logic [DATA_W-1:0]          rdata,
    output logic                       done,
    output logic                       stall
);

    // Controller to datapath
    logic cache_we;
    logic cache_in_select;
    logic mem_in_select;
    logic mem_start;
    logic mem_we;

    // Datapath to controller
    logic hit;
    logic dirty;

    // Array ports
    logic [INDEX_W-1:0]     index;
    dcache_pkg::tag_entry_t rtag;
    dcache_pkg::tag_entry_t wtag;
    logic [DATA_W-1:0]      rdata_line;
    logic [DATA_W-1:0]      wdata_line;

    // Memory side
    dcache_pkg::mem_req_t mem_req;
    dcache_pkg::mem_rsp_t mem_rsp;

    cache_ctrl ctrl0 (
        .clk             (clk),
        .rst_b           (rst_b),
        .opcode          (req.opcode),
        .hit             (hit),
        .dirty           (dirty),
        .mem_ready       (mem_rsp.ready),
        .cache_we        (cache_we),
        .cache_in_select (cache_in_select),
        .mem_in_select   (mem_in_select),
        .mem_start       (mem_start),
        .mem_we          (mem_we),
        .done            (done),
        .stall           (stall)
    );

    cache_datapath #(
        .ADDR_W  (ADDR_W),
        .INDEX_W (INDEX_W),
        .DATA_W  (DATA_W)
    ) dp0 (
        .req             (req),
        .rtag            (rtag),
        .rdata_line      (rdata_line),
        .cache_in_select (cache_in_select),
        .mem_in_select   (mem_in_select),
        .mem_start       (mem_start),
        .mem_we          (mem_we),
        .mem_rsp         (mem_rsp),
        .hit             (hit),
        .dirty           (dirty),
        .index           (index),
        .wtag            (wtag),
        .wdata_line      (wdata_line),
        .mem_req         (mem_req),
        .rdata           (rdata)
    );

    line_array #(
        .entry_t (dcache_pkg::tag_entry_t),
        .INDEX_W (INDEX_W)
    ) tags0 (
        .clk    (clk),
        .rst_b  (rst_b),
        .index  (index),
        .we     (cache_we),
        .wentry (wtag),
        .rentry (rtag)
    );

    line_array #(
        .entry_t (logic [DATA_W-1:0]),
        .INDEX_W (INDEX_W)
    ) data0 (
        .clk    (clk),
        .rst_b  (rst_b),
        .index  (index),
        .we     (cache_we),
        .wentry (wdata_line),
        .rentry (rdata_line)
    );

    main_mem #(
        .MEM_LAT (MEM_LAT),
        .ADDR_W  (ADDR_W),
        .DATA_W  (DATA_W)
    ) mem0 (
        .clk   (clk),
        .rst_b (rst_b),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== dcache_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_assert (
    input wire                          clk,
    input wire                          rst_b,
    input wire dcache_pkg::ctrl_state_t state,
    input wire                          mem_start,
    input wire                          done,
    input wire                          stall,
    input wire                          cache_we,
    input wire                          cache_in_select
);

    int fail_cnt;

    initial fail_cnt = 0;

    // Memory access only starts in a memory phase
    start_in_mem_phase: assert property (@(posedge clk) disable iff (!rst_b)
        mem_start |-> (state == dcache_pkg::WRITEBACK || state == dcache_pkg::REFILL))
    else begin
        $error("mem_start high outside WRITEBACK and REFILL");
        fail_cnt++;
    end

    done_not_stalled: assert property (@(posedge clk) disable iff (!rst_b)
        !(done && stall))
    else begin
        $error("done and stall high in the same cycle");
        fail_cnt++;
    end

    // Fill from memory data belongs to REFILL
    refill_write_in_refill: assert property (@(posedge clk) disable iff (!rst_b)
        (cache_we && !cache_in_select) |-> (state == dcache_pkg::REFILL))
    else begin
        $error("line filled from memory outside REFILL");
        fail_cnt++;
    end

endmodule

bind cache_ctrl dcache_assert assert0 (
    .clk             (clk),
    .rst_b           (rst_b),
    .state           (state),
    .mem_start       (mem_start),
    .done            (done),
    .stall           (stall),
    .cache_we        (cache_we),
    .cache_in_select (cache_in_select)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_b
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // Released 1 ns after an edge, like the other inputs
    initial begin
        rst_b = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_b = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int ADDR_W       = dcache_pkg::ADDR_W;
    localparam int INDEX_W      = dcache_pkg::INDEX_W;
    localparam int DATA_W       = dcache_pkg::DATA_W;
    localparam int MEM_LAT      = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ACCESSES = 49;
    localparam int MAX_CYCLES   = NUM_ACCESSES * (2 * MEM_LAT + 4) + RESET_CYCLES;

    logic                 clk;
    logic                 rst_b;
    dcache_pkg::cpu_req_t req;
    logic [DATA_W-1:0]    rdata;
    logic                 done;
    logic                 stall;

    // Expected memory contents
    logic [DATA_W-1:0] shadow [2 ** ADDR_W];
    int                errors;
    int                checks;
    int                tests;
    int                cycle_cnt;

    tb_clk_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk0 (
        .clk   (clk),
        .rst_b (rst_b)
    );

    dcache_top #(
        .ADDR_W  (ADDR_W),
        .INDEX_W (INDEX_W),
        .DATA_W  (DATA_W),
        .MEM_LAT (MEM_LAT)
    ) dut0 (
        .clk   (clk),
        .rst_b (rst_b),
        .req   (req),
        .rdata (rdata),
        .done  (done),
        .stall (stall)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("ERROR: timeout, the run is still busy after %0d cycles", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================
    // Starts at 1 ns after an edge and returns there, the request still held
    task automatic cpu_access(input logic [5:0] op, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rd,
                              output logic stall_seen);
        logic finished;
        req.opcode = op;
        req.addr   = addr;
        req.wdata  = wdata;
        finished   = 1'b0;
        stall_seen = 1'b0;
        rd         = '0;
        while (!finished) begin
            // Mid-cycle sample
            @(negedge clk);
            stall_seen = stall_seen | stall;
            if (done) begin
                finished = 1'b1;
                rd       = rdata;
            end
            @(posedge clk);
            #1;
        end
        if (op == dcache_pkg::OP_SW) begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic compare_word(input string name, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] expected,
                                input logic [DATA_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s addr=%h expected=%h actual=%h", name, addr, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%-16s passed", name);
        end else begin
            $display("%-16s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ====================
    // Tests
    // ====================
    task automatic reset_read();
        logic [DATA_W-1:0] rd;
        logic              stalled;
        int                errors_before;
        errors_before = errors;
        cpu_access(dcache_pkg::OP_LW, 10'h3c7, '0, rd, stalled);
        compare_word("reset_read", 10'h3c7, shadow[10'h3c7], rd);
        checks++;
        if (!stalled) begin
            errors++;
            $display("ERROR reset_read: the first load completed without a stall");
        end
        report_test("reset_read", errors_before);
    endtask

    task automatic store_load_same();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] word;
        logic              stalled;
        int                errors_before;
        errors_before = errors;
        word = $urandom;
        cpu_access(dcache_pkg::OP_SW, 10'h0a2, word, rd, stalled);
        cpu_access(dcache_pkg::OP_LW, 10'h0a2, '0, rd, stalled);
        compare_word("store_load_same", 10'h0a2, word, rd);
        checks++;
        if (stalled) begin
            errors++;
            $display("ERROR store_load_same: the load after the store stalled on a hit");
        end
        report_test("store_load_same", errors_before);
    endtask

    task automatic clean_eviction();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] word;
        logic              stalled;
        int                errors_before;
        errors_before = errors;
        word = $urandom;
        // Same index 5, tags 0x10 and 0x20
        // Nonzero word for 0x205 reaches memory when 0x105 evicts it
        cpu_access(dcache_pkg::OP_SW, 10'h205, word, rd, stalled);
        cpu_access(dcache_pkg::OP_LW, 10'h105, '0, rd, stalled);
        compare_word("clean_eviction", 10'h105, shadow[10'h105], rd);
        // Clean victim, refilled straight from memory
        cpu_access(dcache_pkg::OP_LW, 10'h205, '0, rd, stalled);
        compare_word("clean_eviction", 10'h205, shadow[10'h205], rd);
        report_test("clean_eviction", errors_before);
    endtask

    task automatic dirty_writeback();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] first;
        logic              stalled;
        int                errors_before;
        errors_before = errors;
        first = $urandom;
        cpu_access(dcache_pkg::OP_SW, 10'h019, first, rd, stalled);
        // Evicts the dirty line at index 9
        cpu_access(dcache_pkg::OP_SW, 10'h139, $urandom, rd, stalled);
        cpu_access(dcache_pkg::OP_LW, 10'h019, '0, rd, stalled);
        compare_word("dirty_writeback", 10'h019, first, rd);
        report_test("dirty_writeback", errors_before);
    endtask

    task automatic random_mix();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] expected;
        logic [ADDR_W-1:0] addr;
        logic              stalled;
        int                errors_before;
        errors_before = errors;
        for (int i = 0; i < 40; i++) begin
            addr = ADDR_W'($urandom_range(63, 0));
            if ($urandom_range(1, 0) == 1) begin
                cpu_access(dcache_pkg::OP_SW, addr, $urandom, rd, stalled);
            end else begin
                expected = shadow[addr];
                cpu_access(dcache_pkg::OP_LW, addr, '0, rd, stalled);
                compare_word("random_mix", addr, expected, rd);
            end
        end
        report_test("random_mix", errors_before);
    endtask

    initial begin
        int unsigned seed_sink;
        seed_sink = $urandom(32'h3a3e3085);
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cycle_cnt = 0;
        req       = '0;
        for (int i = 0; i < 2 ** ADDR_W; i++) begin
            shadow[i] = '0;
        end

        wait (rst_b === 1'b1);
        @(posedge clk);
        #1;

        reset_read();
        store_load_same();
        clean_eviction();
        dirty_writeback();
        random_mix();
        req.opcode = '0;

        if (dut0.ctrl0.assert0.fail_cnt != 0) begin
            $display("ERROR: %0d assertion failures in cache_ctrl", dut0.ctrl0.assert0.fail_cnt);
            errors = errors + dut0.ctrl0.assert0.fail_cnt;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
dcache_pkg.sv
line_array.sv
cache_ctrl.sv
cache_datapath.sv
main_mem.sv
dcache_top.sv
dcache_assert.sv
tb_clk_gen.sv
dcache_tb.sv
